// File: Makefile
# Verilator build for the spi to word memory bridge
TOP := spi_ram_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --top-module $(TOP) -Mdir obj_dir -f list.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: list.f
logic/spi_pkg.sv
logic/mem_pkg.sv
logic/byte_bus_if.sv
logic/word_bus_if.sv
logic/spi_slave.sv
logic/byte_packer.sv
logic/word_store.sv
logic/spi_ram_top.sv
test/spi_ram_tb.sv

// File: logic/byte_bus_if.sv
// byte strobes from the spi slave to the packer
interface byte_bus_if;

  logic               rd;    // one clk, fetch byte at addr
  logic               wr;    // one clk, wdata to addr
  spi_pkg::spi_addr_t addr;  // valid during rd or wr
  spi_pkg::byte_t     wdata; // valid during wr
  spi_pkg::byte_t     rdata; // valid 2 clk after rd, held until next rd

  modport slave (
    output rd, wr, addr, wdata,
    input  rdata
  );

  modport packer (
    input  rd, wr, addr, wdata,
    output rdata
  );

endinterface

// File: logic/byte_packer.sv
// region decode, control byte and byte-to-word packing
module byte_packer (
  input  logic           clk,
  input  logic           reset,
  byte_bus_if.packer     bus,
  word_bus_if.packer     mem,
  output spi_pkg::byte_t control
);

  mem_pkg::region_t    region;      // of the strobed address
  logic                is_mem;
  logic                is_ctrl;

  spi_pkg::byte_t      control_q;
  logic                we_q;
  logic                re_q;
  mem_pkg::word_addr_t word_addr_q;
  spi_pkg::byte_t      even_byte;   // waits for its odd partner
  spi_pkg::byte_t      odd_byte;
  mem_pkg::region_t    rd_region_q; // region of the last rd
  logic                rd_low_q;    // odd address picks low half

  assign region  = bus.addr[31:24];
  assign is_mem  = (region == mem_pkg::REGION_MEM);
  assign is_ctrl = (region == mem_pkg::REGION_CTRL);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      control_q   <= '0;
      we_q        <= 1'b0;
      re_q        <= 1'b0;
      rd_region_q <= '0;
    end
    else
    begin
      we_q <= bus.wr & is_mem & bus.addr[0]; // odd byte completes the word
      re_q <= bus.rd & is_mem;
      if (bus.wr && is_ctrl)
        control_q <= bus.wdata;
      if (bus.rd)
        rd_region_q <= region;
    end
  end

  // payload, no reset
  always_ff @(posedge clk)
  begin
    if (bus.wr || bus.rd)
      word_addr_q <= bus.addr[mem_pkg::WORD_ADDR_BITS:1];
    if (bus.wr && is_mem)
    begin
      if (bus.addr[0])
        odd_byte <= bus.wdata;
      else
        even_byte <= bus.wdata;
    end
    if (bus.rd)
      rd_low_q <= bus.addr[0];
  end

  // read byte select
  always_comb
  begin
    if (rd_region_q == mem_pkg::REGION_MEM)
      bus.rdata = rd_low_q ? mem.rdata[7:0] : mem.rdata[15:8];
    else if (rd_region_q == mem_pkg::REGION_CTRL)
      bus.rdata = control_q;
    else
      bus.rdata = '0; // unmapped
  end

  assign mem.we    = we_q;
  assign mem.re    = re_q;
  assign mem.addr  = word_addr_q;
  assign mem.wdata = {even_byte, odd_byte}; // even byte high
  assign control   = control_q;

endmodule

// File: logic/mem_pkg.sv
// memory side of the bridge: word store and address regions
package mem_pkg;

  // one stored word, even byte in the high half
  typedef logic [15:0] word_t;

  // 256 words stand in for the external sdram
  localparam int WORD_ADDR_BITS = 8;

  // word index, taken from byte address bits 8:1
  typedef logic [WORD_ADDR_BITS-1:0] word_addr_t;

  // top byte of the 32-bit address
  typedef logic [7:0] region_t;

  localparam region_t REGION_MEM  = 8'h00; // word memory
  localparam region_t REGION_CTRL = 8'hFF; // control byte

  // every other region reads 00 and drops writes

endpackage

// File: logic/spi_pkg.sv
// byte-level view of the spi host link
package spi_pkg;

  // one byte on mosi or miso
  typedef logic [7:0] byte_t;

  // full byte address, sent msb first after the command
  typedef logic [31:0] spi_addr_t;

  // command byte opcodes
  localparam byte_t CMD_WRITE = 8'h02; // data bytes follow, host to memory
  localparam byte_t CMD_READ  = 8'h03; // data bytes clocked back on miso

  // address bytes between command and data
  localparam int ADDR_BYTES = 4;

endpackage

// File: logic/spi_ram_top.sv
// spi to word memory bridge, single clock
module spi_ram_top (
  input  logic           clk,
  input  logic           reset,
  input  logic           spi_csn,
  input  logic           spi_sclk,
  input  logic           spi_mosi,
  output logic           spi_miso,
  output spi_pkg::byte_t control
);

  byte_bus_if byte_bus (); // slave to packer
  word_bus_if word_bus (); // packer to store

  // byte strobes from the spi pins
  spi_slave u_spi_slave (
    .clk      (clk),
    .reset    (reset),
    .spi_csn  (spi_csn),
    .spi_sclk (spi_sclk),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso),
    .bus      (byte_bus.slave)
  );

  // bytes into words, control byte
  byte_packer u_byte_packer (
    .clk     (clk),
    .reset   (reset),
    .bus     (byte_bus.packer),
    .mem     (word_bus.packer),
    .control (control)
  );

  word_store u_word_store (
    .clk (clk),
    .mem (word_bus.store)
  );

endmodule

// File: logic/spi_slave.sv
// spi mode 0 slave, oversampled on clk
module spi_slave (
  input  logic        clk,
  input  logic        reset,
  input  logic        spi_csn,
  input  logic        spi_sclk,
  input  logic        spi_mosi,
  output logic        spi_miso,
  byte_bus_if.slave   bus
);

  typedef enum logic [2:0] {
    ph_cmd,     // waiting for command byte
    ph_addr,    // collecting address bytes
    ph_data_wr, // write data bytes
    ph_data_rd, // read data bytes
    ph_ignore   // unknown command, wait for csn
  } phase_t;

  phase_t phase;

  // two-flop synchronizers, index 1 is the safe one
  logic [1:0] sclk_sync;
  logic [1:0] csn_sync;
  logic [1:0] mosi_sync;
  logic       sclk_prev; // for edge detect

  logic       sclk_rise;
  logic       sclk_fall;
  logic       byte_done;

  logic [2:0] bit_cnt;  // bits of the current byte
  logic [1:0] byte_cnt; // address bytes seen
  logic       rd_cmd;   // command was a read

  logic [6:0]         shift_in;  // mosi bits so far
  spi_pkg::byte_t     byte_in;   // byte completed by this rise
  spi_pkg::byte_t     shift_out; // miso byte, msb out
  spi_pkg::spi_addr_t addr_q;
  spi_pkg::byte_t     wdata_q;
  logic               wr_q;
  logic               rd_q;
  logic [1:0]         rd_pipe;   // rd delayed until rdata settles

  assign sclk_rise = sclk_sync[1] & ~sclk_prev;
  assign sclk_fall = ~sclk_sync[1] & sclk_prev;
  assign byte_in   = {shift_in, mosi_sync[1]};
  assign byte_done = sclk_rise & (bit_cnt == 3'd7) & ~csn_sync[1];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sclk_sync <= 2'b00;
      csn_sync  <= 2'b11; // bus idle
      mosi_sync <= 2'b00;
      sclk_prev <= 1'b0;
      phase     <= ph_cmd;
      bit_cnt   <= '0;
      byte_cnt  <= '0;
      rd_cmd    <= 1'b0;
      wr_q      <= 1'b0;
      rd_q      <= 1'b0;
      rd_pipe   <= '0;
      shift_out <= '0;
    end
    else
    begin
      sclk_sync <= {sclk_sync[0], spi_sclk};
      csn_sync  <= {csn_sync[0], spi_csn};
      mosi_sync <= {mosi_sync[0], spi_mosi};
      sclk_prev <= sclk_sync[1];
      wr_q      <= 1'b0; // strobes last one clk
      rd_q      <= 1'b0;
      rd_pipe   <= {rd_pipe[0], rd_q};
      if (csn_sync[1])
      begin
        // deselected: drop partial byte, back to command
        phase     <= ph_cmd;
        bit_cnt   <= '0;
        byte_cnt  <= '0;
        shift_out <= '0;
      end
      else
      begin
        if (rd_pipe[1])
          shift_out <= bus.rdata; // bit 7 shows before next rise
        else if (sclk_fall && bit_cnt != 3'd0)
          shift_out <= {shift_out[6:0], 1'b0}; // no shift on fall after a full byte
        if (sclk_rise)
          bit_cnt <= bit_cnt + 3'd1;
        if (byte_done)
        begin
          case (phase)
            ph_cmd:
            begin
              if (byte_in == spi_pkg::CMD_WRITE)
              begin
                rd_cmd <= 1'b0;
                phase  <= ph_addr;
              end
              else if (byte_in == spi_pkg::CMD_READ)
              begin
                rd_cmd <= 1'b1;
                phase  <= ph_addr;
              end
              else
                phase <= ph_ignore;
            end
            ph_addr:
            begin
              byte_cnt <= byte_cnt + 2'd1;
              if (byte_cnt == 2'(spi_pkg::ADDR_BYTES - 1))
              begin
                if (rd_cmd)
                begin
                  phase <= ph_data_rd;
                  rd_q  <= 1'b1; // prefetch first byte
                end
                else
                  phase <= ph_data_wr;
              end
            end
            ph_data_wr: wr_q <= 1'b1;
            ph_data_rd: rd_q <= 1'b1; // fetch following byte
            default: ; // ignore until csn rises
          endcase
        end
      end
    end
  end

  // shift and address path
  always_ff @(posedge clk)
  begin
    if (sclk_rise)
      shift_in <= byte_in[6:0];
    if (byte_done && phase == ph_addr)
      addr_q <= {addr_q[23:0], byte_in}; // msb first
    else if (byte_done && phase == ph_data_rd)
      addr_q <= addr_q + 32'd1; // in step with rd
    else if (wr_q)
      addr_q <= addr_q + 32'd1; // after the write strobe
    if (byte_done && phase == ph_data_wr)
      wdata_q <= byte_in;
  end

  assign bus.wr    = wr_q;
  assign bus.rd    = rd_q;
  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;
  assign spi_miso  = shift_out[7];

endmodule

// File: logic/word_bus_if.sv
// word strobes from the packer to the word store
interface word_bus_if;

  logic                we;    // one clk write
  logic                re;    // one clk read
  mem_pkg::word_addr_t addr;  // shared by reads and writes
  mem_pkg::word_t      wdata; // valid with we
  mem_pkg::word_t      rdata; // registered, valid 1 clk after re

  modport packer (
    output we, re, addr, wdata,
    input  rdata
  );

  modport store (
    input  we, re, addr, wdata,
    output rdata
  );

endinterface

// File: logic/word_store.sv
// on-chip word memory standing in for the sdram
module word_store (
  input  logic      clk,
  word_bus_if.store mem
);

  // contents undefined after power-up
  mem_pkg::word_t ram [1 << mem_pkg::WORD_ADDR_BITS];

  always_ff @(posedge clk)
  begin
    if (mem.we)
      ram[mem.addr] <= mem.wdata;
  end

  // registered read, held between reads
  always_ff @(posedge clk)
  begin
    if (mem.re)
      mem.rdata <= ram[mem.addr];
  end

endmodule

// File: test/spi_ram_tb.sv
// host side model for the spi to word memory bridge
module spi_ram_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // about 175 spi bytes at 64 clk each, plus csn gaps, roughly 11.5k cycles
  localparam int timeout_cycles = 20000;

  logic           clk;
  logic           reset;
  logic           spi_csn;
  logic           spi_sclk;
  logic           spi_mosi;
  logic           spi_miso;
  spi_pkg::byte_t control;

  spi_pkg::byte_t model [256]; // region 00 bytes as stored in the word memory
  spi_pkg::byte_t tx_bytes[$];  // data bytes of the next write
  spi_pkg::byte_t exp_bytes[$]; // expected bytes of the next read
  spi_pkg::byte_t ctrl_val;     // last value written to the control byte
  integer         seed;
  int             cycles;

  spi_ram_top u_dut (
    .clk      (clk),
    .reset    (reset),
    .spi_csn  (spi_csn),
    .spi_sclk (spi_sclk),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso),
    .control  (control)
  );

  always #4 clk = ~clk; // 8 ns period

  // run limit
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= timeout_cycles)
    begin
      $display("timeout: no end of test after %0d clock cycles", cycles);
      abort_run("run did not finish in time");
    end
  end

  task automatic abort_run(input string why);
    $display("TESTBENCH FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_byte(input string name, input spi_pkg::byte_t exp,
                            input spi_pkg::byte_t act);
    assert (act === exp)
    else
    begin
      $display("MISMATCH %s expected %02h actual %02h", name, exp, act);
      abort_run("received byte differs from the model");
    end
  endtask

  // n rising edges, then 1 ns on to the drive point
  task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // mode 0, msb first; nbits below 8 leaves a partial byte
  task automatic spi_shift(input spi_pkg::byte_t tx, input int nbits,
                           output spi_pkg::byte_t rx);
    int i;
    rx = '0;
    for (i = 7; i > 7 - nbits; i--)
    begin
      spi_mosi = tx[i];
      wait_clocks(4);   // sclk low phase
      rx[i] = spi_miso; // sampled just before the rise
      spi_sclk = 1'b1;
      wait_clocks(4);   // high phase
      spi_sclk = 1'b0;
    end
  endtask

  // select, command byte, then address msb first
  task automatic spi_header(input spi_pkg::byte_t cmd, input spi_pkg::spi_addr_t addr);
    spi_pkg::byte_t unused;
    int             k;
    spi_csn = 1'b0;
    wait_clocks(2);
    spi_shift(cmd, 8, unused);
    for (k = 0; k < spi_pkg::ADDR_BYTES; k++)
      spi_shift(addr[8*(spi_pkg::ADDR_BYTES-1-k) +: 8], 8, unused);
  endtask

  task automatic spi_end;
    wait_clocks(4);
    spi_csn = 1'b1;
    wait_clocks(8); // long enough for the slave to see csn high
  endtask

  task automatic write_bytes(input spi_pkg::spi_addr_t addr);
    spi_pkg::byte_t unused;
    spi_header(spi_pkg::CMD_WRITE, addr);
    foreach (tx_bytes[k])
      spi_shift(tx_bytes[k], 8, unused);
    spi_end();
  endtask

  task automatic read_and_check(input string name, input spi_pkg::spi_addr_t addr);
    spi_pkg::byte_t rx;
    spi_header(spi_pkg::CMD_READ, addr);
    foreach (exp_bytes[k])
    begin
      spi_shift(8'h00, 8, rx);
      check_byte(name, exp_bytes[k], rx);
    end
    spi_end();
  endtask

  // expected read bytes straight from the region 00 model
  task automatic expect_model(input int base, input int n);
    int k;
    exp_bytes.delete();
    for (k = 0; k < n; k++)
      exp_bytes.push_back(model[base + k]);
  endtask

  // n fresh random bytes queued for the next write
  task automatic random_tx(input int n);
    int k;
    tx_bytes.delete();
    for (k = 0; k < n; k++)
      tx_bytes.push_back(8'($random(seed)));
  endtask

  initial
  begin
    spi_pkg::byte_t unused;
    int             i;
    clk      = 1'b0;
    reset    = 1'b1;
    spi_csn  = 1'b1; // bus idle
    spi_sclk = 1'b0; // mode 0 idle level
    spi_mosi = 1'b0;
    cycles   = 0;
    seed     = 32'hd250;
    for (i = 0; i < 256; i++)
      model[i] = 8'($random(seed));
    wait_clocks(3);
    reset = 1'b0;
    wait_clocks(1);

    // reset_state
    check_byte("reset_state", 8'h00, control);
    check_byte("reset_state", 8'h00, {7'd0, spi_miso});

    // memory is undefined after reset, load 40..5f from the model
    tx_bytes.delete();
    for (i = 'h40; i < 'h60; i++)
      tx_bytes.push_back(model[i]);
    write_bytes(32'h0000_0040);

    // control_write
    random_tx(1);
    ctrl_val = tx_bytes[0];
    write_bytes(32'hFF00_0000);
    check_byte("control_write", ctrl_val, control);
    exp_bytes.delete();
    exp_bytes.push_back(ctrl_val);
    read_and_check("control_write", 32'hFF00_0000);

    // burst_readback, whole words 20..3f
    random_tx(32);
    for (i = 0; i < 32; i++)
      model['h20 + i] = tx_bytes[i];
    write_bytes(32'h0000_0020);
    expect_model('h20, 32);
    read_and_check("burst_readback", 32'h0000_0020);

    // odd_pending, third byte waits for a partner that never comes
    random_tx(3);
    model['h40] = tx_bytes[0];
    model['h41] = tx_bytes[1];
    write_bytes(32'h0000_0040);
    expect_model('h40, 4);
    read_and_check("odd_pending", 32'h0000_0040);

    // unmapped_region, same low bits as a loaded word
    random_tx(2);
    write_bytes(32'h1200_0040);
    check_byte("unmapped_region", ctrl_val, control);
    exp_bytes.delete();
    exp_bytes.push_back(8'h00);
    exp_bytes.push_back(8'h00);
    read_and_check("unmapped_region", 32'h1200_0040);
    expect_model('h40, 2);
    read_and_check("unmapped_region", 32'h0000_0040);

    // csn_abort: even byte sent, odd byte cut after 5 bits
    spi_header(spi_pkg::CMD_WRITE, 32'h0000_0050);
    spi_shift(8'($random(seed)), 8, unused);
    spi_shift(8'($random(seed)), 5, unused);
    spi_end();
    expect_model('h50, 2);
    read_and_check("csn_abort", 32'h0000_0050);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule
